// ==== logic/pipe_pkg.sv ====
// Shared register index type and pipeline constants for the operand stage.
// Every module imports this package with a wildcard import.

`default_nettype none

package pipe_pkg;

    // ------------------------------------------------------------------
    // Register file geometry
    // ------------------------------------------------------------------

    parameter int REG_ADDR_W = 5;               // Bits in a register index

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // Architectural register index

    parameter int REG_COUNT = 32;               // Architectural GPRs

    // ------------------------------------------------------------------
    // Operand stage constants
    // ------------------------------------------------------------------

    parameter int NUM_SRC = 3;                  // rs1, rs2 and rs3

    // Hard-wired zero register. Upstream stages also use this index as
    // "no producer" on their rd field.
    parameter reg_addr_t ZERO_REG = '0;

endpackage

`default_nettype wire

// ==== logic/gpr_file.sv ====
// General purpose register file with three combinational read ports.
// A single write port stores one word, or a low/high pair into an even/odd
// register pair when rd_wide is set.

`timescale 1ns/1ps
`default_nettype none

module gpr_file import pipe_pkg::*; #(
    parameter int XLEN = 32                   // Data word width
) (
    input  wire              g_clk,           // Global clock
    input  wire              reset,           // Sync reset, active high
    input  reg_addr_t        rs1_addr,        // Source register 1 index
    input  reg_addr_t        rs2_addr,        // Source register 2 index
    input  reg_addr_t        rs3_addr,        // Source register 3 index
    output logic [XLEN-1:0]  rs1_data,        // Source register 1 data
    output logic [XLEN-1:0]  rs2_data,        // Source register 2 data
    output logic [XLEN-1:0]  rs3_data,        // Source register 3 data
    input  wire              rd_wen,          // Write enable
    input  wire              rd_wide,         // Write a register pair
    input  reg_addr_t        rd_addr,         // Destination index, even if wide
    input  wire  [XLEN-1:0]  rd_wdata,        // Low word
    input  wire  [XLEN-1:0]  rd_wdata_hi      // High word, odd partner
);

    logic [XLEN-1:0] regs [REG_COUNT];        // Storage array

    reg_addr_t       hi_addr;                 // Odd partner of rd_addr

    assign hi_addr = {rd_addr[REG_ADDR_W-1:1], 1'b1};

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;                // Architectural state cleared
            end
        end else if (rd_wen) begin
            if (rd_addr != ZERO_REG) begin
                regs[rd_addr] <= rd_wdata;    // Low word, x0 discarded
            end
            if (rd_wide) begin
                regs[hi_addr] <= rd_wdata_hi; // Pair half
            end
        end
    end

    // Read ports, old value visible during the write cycle
    assign rs1_data = (rs1_addr == ZERO_REG) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == ZERO_REG) ? '0 : regs[rs2_addr];
    assign rs3_data = (rs3_addr == ZERO_REG) ? '0 : regs[rs3_addr];

    // Pair writes must start on an even register
    a_wide_even: assert property (@(posedge g_clk) disable iff (reset)
        (rd_wen && rd_wide) |-> !rd_addr[0])
        else $error("gpr_file: wide write to odd register %0d", rd_addr);

endmodule

`default_nettype wire

// ==== logic/operand_forward.sv ====
// Hazard detection and forwarding for a single source operand.
// Compares the source index against the execute, memory and writeback
// producers, picks the youngest match and flags a stall on late results.

`timescale 1ns/1ps
`default_nettype none

module operand_forward import pipe_pkg::*; #(
    parameter int XLEN = 32                   // Data word width
) (
    input  reg_addr_t        src_addr,        // Source register index
    input  wire  [XLEN-1:0]  rf_data,         // Register file read data
    input  reg_addr_t        ex_rd,           // Execute producer rd
    input  wire              ex_wide,         // Execute writes a pair
    input  wire              ex_late,         // Execute result not ready
    input  wire  [XLEN-1:0]  ex_wdata,        // Execute low word
    input  wire  [XLEN-1:0]  ex_wdata_hi,     // Execute high word
    input  reg_addr_t        mem_rd,          // Memory producer rd
    input  wire              mem_wide,        // Memory writes a pair
    input  wire              mem_late,        // Memory result not ready
    input  wire  [XLEN-1:0]  mem_wdata,       // Memory low word
    input  wire  [XLEN-1:0]  mem_wdata_hi,    // Memory high word
    input  wire              wb_wen,          // Writeback commits this cycle
    input  reg_addr_t        wb_rd,           // Writeback rd
    input  wire              wb_wide,         // Writeback writes a pair
    input  wire              wb_late,         // Writeback result not ready
    input  wire  [XLEN-1:0]  wb_wdata,        // Writeback low word
    input  wire  [XLEN-1:0]  wb_wdata_hi,     // Writeback high word
    output logic [XLEN-1:0]  opr_data,        // Forwarded operand
    output logic             stall            // Source waits on a late result
);

    // Direct match on a non-zero index, or the odd half of a wide pair
    function automatic logic hit(input reg_addr_t a, input reg_addr_t f, input logic w);
        logic pair_hit;
        pair_hit = w && !f[0] && a[0] && (a[REG_ADDR_W-1:1] == f[REG_ADDR_W-1:1]);
        return ((a != ZERO_REG) && (a == f)) || pair_hit;
    endfunction

    logic ex_hit;
    logic mem_hit;
    logic wb_hit;
    logic src_odd;                            // Odd source takes the high word

    assign ex_hit  = hit(src_addr, ex_rd, ex_wide);
    assign mem_hit = hit(src_addr, mem_rd, mem_wide);
    assign wb_hit  = wb_wen && hit(src_addr, wb_rd, wb_wide);
    assign src_odd = src_addr[0];

    // Youngest producer wins
    assign opr_data =
        ex_hit  ? ((src_odd && ex_wide)  ? ex_wdata_hi  : ex_wdata)  :
        mem_hit ? ((src_odd && mem_wide) ? mem_wdata_hi : mem_wdata) :
        wb_hit  ? ((src_odd && wb_wide)  ? wb_wdata_hi  : wb_wdata)  :
                  rf_data;

    // Any late match stalls, even behind a younger ready match
    assign stall = (ex_hit && ex_late) || (mem_hit && mem_late) || (wb_hit && wb_late);

    // x0 reads as zero through both forwarding and the register file
    always_comb begin
        if (src_addr == ZERO_REG) begin
            a_zero_src: assert final (opr_data == '0)
                else $error("operand_forward: x0 operand is %h", opr_data);
        end
    end

endmodule

`default_nettype wire

// ==== logic/issue_register.sv ====
// Handoff register between decode and execute.
// Accepts an operand set when s1_valid is high and the stage is not busy,
// holds under execute back-pressure and inserts a bubble otherwise.

`timescale 1ns/1ps
`default_nettype none

module issue_register import pipe_pkg::*; #(
    parameter int XLEN = 32                   // Data word width
) (
    input  wire              g_clk,           // Global clock
    input  wire              reset,           // Sync reset, active high
    input  wire              flush,           // Drop the held item
    input  wire              s1_valid,        // Decode has an item
    input  wire              stall,           // Operand hazard on a late result
    input  wire              s2_busy,         // Execute cannot take an item
    input  reg_addr_t        s1_rd,           // Destination of the decode item
    input  wire  [XLEN-1:0]  s1_opr_a,        // Forwarded operand A
    input  wire  [XLEN-1:0]  s1_opr_b,        // Forwarded operand B
    input  wire  [XLEN-1:0]  s1_opr_c,        // Forwarded operand C
    output logic             s1_busy,         // Decode must hold its item
    output logic             s2_valid,        // Execute item valid
    output reg_addr_t        s2_rd,           // Execute destination
    output logic [XLEN-1:0]  s2_opr_a,        // Execute operand A
    output logic [XLEN-1:0]  s2_opr_b,        // Execute operand B
    output logic [XLEN-1:0]  s2_opr_c         // Execute operand C
);

    logic hold;                               // Execute still owns the item
    logic accept;                             // Item moves on this edge

    assign hold    = s2_valid && s2_busy;
    assign s1_busy = stall || hold;
    assign accept  = s1_valid && !s1_busy;

    // ------------------------------------------------------------------
    // Valid flag, bubble when free and nothing is accepted
    // ------------------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (reset) begin
            s2_valid <= 1'b0;
        end else if (flush) begin
            s2_valid <= 1'b0;                 // Flush beats acceptance
        end else if (!hold) begin
            s2_valid <= accept;
        end
    end

    // Payload only moves on acceptance
    always_ff @(posedge g_clk) begin
        if (accept) begin
            s2_rd    <= s1_rd;
            s2_opr_a <= s1_opr_a;
            s2_opr_b <= s1_opr_b;
            s2_opr_c <= s1_opr_c;
        end
    end

    a_hold_payload: assert property (@(posedge g_clk) disable iff (reset)
        hold |=> $stable({s2_rd, s2_opr_a, s2_opr_b, s2_opr_c}))
        else $error("issue_register: payload changed under back-pressure");

endmodule

`default_nettype wire

// ==== logic/operand_issue.sv ====
// Operand side of the decode stage.
// Reads three sources from the register file, forwards from the execute,
// memory and writeback producers, and registers the result for execute.

`timescale 1ns/1ps
`default_nettype none

module operand_issue import pipe_pkg::*; #(
    parameter int XLEN = 32                   // Data word width, 32 or 64
) (
    input  wire              g_clk,           // Global clock
    input  wire              reset,           // Sync reset, active high
    input  wire              s1_valid,        // Decode item valid
    input  reg_addr_t        s1_rs1_addr,     // Source 1 index
    input  reg_addr_t        s1_rs2_addr,     // Source 2 index
    input  reg_addr_t        s1_rs3_addr,     // Source 3 index
    input  reg_addr_t        s1_rd,           // Destination index
    output logic             s1_busy,         // Decode must hold
    input  wire              flush,           // Pipeline flush
    input  wire              s2_busy,         // Execute back-pressure
    output logic             s2_valid,        // Execute item valid
    output reg_addr_t        s2_rd,           // Execute destination
    output logic [XLEN-1:0]  s2_opr_a,        // Operand A
    output logic [XLEN-1:0]  s2_opr_b,        // Operand B
    output logic [XLEN-1:0]  s2_opr_c,        // Operand C
    input  reg_addr_t        ex_rd,           // Execute producer
    input  wire              ex_wide,
    input  wire              ex_late,
    input  wire  [XLEN-1:0]  ex_wdata,
    input  wire  [XLEN-1:0]  ex_wdata_hi,
    input  reg_addr_t        mem_rd,          // Memory producer
    input  wire              mem_wide,
    input  wire              mem_late,
    input  wire  [XLEN-1:0]  mem_wdata,
    input  wire  [XLEN-1:0]  mem_wdata_hi,
    input  wire              wb_wen,          // Writeback producer and GPR write
    input  reg_addr_t        wb_rd,
    input  wire              wb_wide,
    input  wire              wb_late,
    input  wire  [XLEN-1:0]  wb_wdata,
    input  wire  [XLEN-1:0]  wb_wdata_hi
);

    reg_addr_t          src_addr  [NUM_SRC];  // Source indexes, rs1 first
    logic [XLEN-1:0]    rf_data   [NUM_SRC];  // Raw register file reads
    logic [XLEN-1:0]    fwd_data  [NUM_SRC];  // Operands after forwarding
    logic [NUM_SRC-1:0] src_stall;            // Per-source late hazard
    logic               stall;

    assign src_addr[0] = s1_rs1_addr;
    assign src_addr[1] = s1_rs2_addr;
    assign src_addr[2] = s1_rs3_addr;

    assign stall = |src_stall;                // Any late hazard bubbles

    // ------------------------------------------------------------------
    // Register file, written straight from writeback
    // ------------------------------------------------------------------

    gpr_file #(.XLEN(XLEN)) u_gprs (
        .g_clk       (g_clk       ),
        .reset       (reset       ),
        .rs1_addr    (src_addr[0] ),
        .rs2_addr    (src_addr[1] ),
        .rs3_addr    (src_addr[2] ),
        .rs1_data    (rf_data[0]  ),
        .rs2_data    (rf_data[1]  ),
        .rs3_data    (rf_data[2]  ),
        .rd_wen      (wb_wen      ),
        .rd_wide     (wb_wide     ),
        .rd_addr     (wb_rd       ),
        .rd_wdata    (wb_wdata    ),
        .rd_wdata_hi (wb_wdata_hi )
    );

    // One forwarder per source operand
    for (genvar i = 0; i < NUM_SRC; i++) begin : g_fwd
        operand_forward #(.XLEN(XLEN)) u_fwd (
            .src_addr     (src_addr[i] ),
            .rf_data      (rf_data[i]  ),
            .ex_rd        (ex_rd       ),
            .ex_wide      (ex_wide     ),
            .ex_late      (ex_late     ),
            .ex_wdata     (ex_wdata    ),
            .ex_wdata_hi  (ex_wdata_hi ),
            .mem_rd       (mem_rd      ),
            .mem_wide     (mem_wide    ),
            .mem_late     (mem_late    ),
            .mem_wdata    (mem_wdata   ),
            .mem_wdata_hi (mem_wdata_hi),
            .wb_wen       (wb_wen      ),
            .wb_rd        (wb_rd       ),
            .wb_wide      (wb_wide     ),
            .wb_late      (wb_late     ),
            .wb_wdata     (wb_wdata    ),
            .wb_wdata_hi  (wb_wdata_hi ),
            .opr_data     (fwd_data[i] ),
            .stall        (src_stall[i])
        );
    end

    // ------------------------------------------------------------------
    // Execute handoff register
    // ------------------------------------------------------------------

    issue_register #(.XLEN(XLEN)) u_issue (
        .g_clk    (g_clk      ),
        .reset    (reset      ),
        .flush    (flush      ),
        .s1_valid (s1_valid   ),
        .stall    (stall      ),
        .s2_busy  (s2_busy    ),
        .s1_rd    (s1_rd      ),
        .s1_opr_a (fwd_data[0]),
        .s1_opr_b (fwd_data[1]),
        .s1_opr_c (fwd_data[2]),
        .s1_busy  (s1_busy    ),
        .s2_valid (s2_valid   ),
        .s2_rd    (s2_rd      ),
        .s2_opr_a (s2_opr_a   ),
        .s2_opr_b (s2_opr_b   ),
        .s2_opr_c (s2_opr_c   )
    );

endmodule

`default_nettype wire

// ==== bench/operand_issue_tb.sv ====
// Testbench for the decode-stage operand path.
// Reads one vector line per cycle, drives the DUT on the rising edge and
// checks s1_busy in the same cycle and the s2 handoff one cycle later.

`timescale 1ns/1ps
`default_nettype none

module operand_issue_tb import pipe_pkg::*; ();

    localparam int XLEN      = 32;             // Word width under test
    localparam int TOKENS    = 13;             // Words per vector line
    localparam int MAX_LINES = 64;

    logic            g_clk;
    logic            reset;
    logic            s1_valid, flush, s2_busy;
    reg_addr_t       s1_rs1_addr, s1_rs2_addr, s1_rs3_addr, s1_rd;
    reg_addr_t       ex_rd, mem_rd, wb_rd;
    logic            ex_wide, ex_late, mem_wide, mem_late, wb_wen, wb_wide, wb_late;
    logic [XLEN-1:0] ex_wdata, ex_wdata_hi, mem_wdata, mem_wdata_hi, wb_wdata, wb_wdata_hi;
    logic            s1_busy, s2_valid;
    reg_addr_t       s2_rd;
    logic [XLEN-1:0] s2_opr_a, s2_opr_b, s2_opr_c;

    logic [31:0]     vec_mem [TOKENS*MAX_LINES]; // Flat image of the vectors file
    int              errors;
    int              checks;

    operand_issue #(.XLEN(XLEN)) DUT (.*);

    always #5 g_clk = ~g_clk;                  // 10 ns period

    // ------------------------------------------------------------------
    // Stimulus and checking helpers
    // ------------------------------------------------------------------

    task automatic drive_line(input int ln);
        int          base;
        logic [31:0] ctrl;
        logic [31:0] addr;
        logic [31:0] prd;
        logic        filler;
        base   = ln * TOKENS;
        ctrl   = vec_mem[base];
        addr   = vec_mem[base+1];
        prd    = vec_mem[base+2];
        filler = !ctrl[16] && !ctrl[0] && !ctrl[3]; // Nothing consumes the data
        s1_valid    <= ctrl[0];
        flush       <= ctrl[1];
        s2_busy     <= ctrl[2];
        wb_wen      <= ctrl[3];
        ex_wide     <= ctrl[4];
        ex_late     <= ctrl[5];
        mem_wide    <= ctrl[6];
        mem_late    <= ctrl[7];
        wb_wide     <= ctrl[8];
        wb_late     <= ctrl[9];
        s1_rs1_addr <= addr[4:0];
        s1_rs2_addr <= addr[12:8];
        s1_rs3_addr <= addr[20:16];
        s1_rd       <= addr[28:24];
        ex_rd       <= prd[4:0];
        mem_rd      <= prd[12:8];
        wb_rd       <= prd[20:16];
        if (filler) begin
            ex_wdata     <= $urandom();        // Random filler words
            ex_wdata_hi  <= $urandom();
            mem_wdata    <= $urandom();
            mem_wdata_hi <= $urandom();
            wb_wdata     <= $urandom();
            wb_wdata_hi  <= $urandom();
        end else begin
            ex_wdata     <= vec_mem[base+3];
            ex_wdata_hi  <= vec_mem[base+4];
            mem_wdata    <= vec_mem[base+5];
            mem_wdata_hi <= vec_mem[base+6];
            wb_wdata     <= vec_mem[base+7];
            wb_wdata_hi  <= vec_mem[base+8];
        end
    endtask

    task automatic drive_idle();
        s1_valid <= 1'b0;
        flush    <= 1'b0;
        s2_busy  <= 1'b0;
        wb_wen   <= 1'b0;
        ex_late  <= 1'b0;
        mem_late <= 1'b0;
        wb_late  <= 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_busy(input int ln);
        check_value("s1_busy", 32'(vec_mem[ln*TOKENS][12]), 32'(s1_busy));
    endtask

    task automatic check_handoff(input int ln);
        int          base;
        logic [31:0] ctrl;
        base = ln * TOKENS;
        ctrl = vec_mem[base];
        if (ctrl[16]) begin
            check_value("s2_valid", 32'(ctrl[17]), 32'(s2_valid));
            if (ctrl[17]) begin                // Payload only matters when valid
                check_value("s2_rd", vec_mem[base+9], 32'(s2_rd));
                check_value("s2_opr_a", vec_mem[base+10], s2_opr_a);
                check_value("s2_opr_b", vec_mem[base+11], s2_opr_b);
                check_value("s2_opr_c", vec_mem[base+12], s2_opr_c);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        int  line;
        int  rst_count;
        logic done;
        g_clk        = 1'b0;
        reset        = 1'b1;
        errors       = 0;
        checks       = 0;
        s1_valid     = 1'b0;
        flush        = 1'b0;
        s2_busy      = 1'b0;
        s1_rs1_addr  = '0;
        s1_rs2_addr  = '0;
        s1_rs3_addr  = '0;
        s1_rd        = '0;
        ex_rd        = '0;
        mem_rd       = '0;
        wb_rd        = '0;
        ex_wide      = 1'b0;
        ex_late      = 1'b0;
        mem_wide     = 1'b0;
        mem_late     = 1'b0;
        wb_wen       = 1'b0;
        wb_wide      = 1'b0;
        wb_late      = 1'b0;
        ex_wdata     = '0;
        ex_wdata_hi  = '0;
        mem_wdata    = '0;
        mem_wdata_hi = '0;
        wb_wdata     = '0;
        wb_wdata_hi  = '0;
        void'($urandom(32'hc6e5));             // One seed for the whole run
        $readmemh("bench/operand_issue_vectors.txt", vec_mem);

        rst_count = 0;
        while (rst_count < 16) begin           // 16 cycles in reset
            @(posedge g_clk);
            rst_count++;
        end
        reset <= 1'b0;
        @(negedge g_clk);
        check_value("s2_valid", 32'h0, 32'(s2_valid)); // Cleared by reset

        line = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge g_clk);
            if (line < MAX_LINES && vec_mem[line*TOKENS][31] !== 1'b1) begin
                drive_line(line);
            end else begin
                drive_idle();
                done = 1'b1;
            end
            @(negedge g_clk);
            if (!done) check_busy(line);
            if (line > 0) check_handoff(line - 1);
            line++;
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog on the whole run
    initial begin
        #20us;
        $display("Timeout: run exceeded its time limit");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/operand_issue_vectors.txt ====
// ctrl addr(rd,rs3,rs2,rs1) prd(wb,mem,ex) ex_d ex_hi mem_d mem_hi wb_d wb_hi
// then expected s2_rd opr_a opr_b opr_c; ctrl bit 12 s1_busy, 16 check, 17 s2_valid
00010000 0 0 0 0 0 0 0 0 0 0 0 0
00010008 0 00050000 0 0 0 0 11110005 0 0 0 0 0
00010008 0 00060000 0 0 0 0 22220006 0 0 0 0 0
00010008 0 00070000 0 0 0 0 33330007 0 0 0 0 0
00010008 0 0 0 0 0 0 deadbeef 0 0 0 0 0
00030001 01070605 0 0 0 0 0 0 0 1 11110005 22220006 33330007
00030001 02000700 0 0 0 0 0 0 0 2 0 33330007 0
00030009 03070605 00050505 e0e0e0e0 0 c0c0c0c0 0 b0b0b0b0 0 3 e0e0e0e0 22220006 33330007
00030009 04060605 00060600 12345678 0 c1c1c1c1 0 b1b1b1b1 0 4 b0b0b0b0 c1c1c1c1 c1c1c1c1
00030009 05000607 00070000 0 0 0 0 77777777 0 5 77777777 b1b1b1b1 0
00030011 06000809 00000008 8888aaaa 9999bbbb 0 0 0 0 6 9999bbbb 8888aaaa 0
00010108 0 000a0000 0 0 0 0 0a0a0a0a 0b0b0b0b 0 0 0 0
00030001 07000b0a 0 0 0 0 0 0 0 7 0a0a0a0a 0b0b0b0b 0
00011081 08000605 00000500 0 0 55555555 0 0 0 0 0 0 0
00011081 08000605 00000606 66666666 0 67676767 0 0 0 0 0 0 0
00030021 09000500 0 01010101 0 0 0 0 0 9 0 b0b0b0b0 0
00030081 0a070605 00000c00 0 0 0c0c0c0c 0 0 0 a b0b0b0b0 b1b1b1b1 77777777
00030001 0b000005 0 0 0 0 0 0 0 b b0b0b0b0 0 0
00031005 0c000006 0 0 0 0 0 0 0 b b0b0b0b0 0 0
00031005 0c000006 0 0 0 0 0 0 0 b b0b0b0b0 0 0
00030001 0c000006 0 0 0 0 0 0 0 c b1b1b1b1 0 0
00010003 0d000005 0 0 0 0 0 0 0 0 0 0 0
00030001 0e000007 0 0 0 0 0 0 0 e 77777777 0 0
00011007 0f000005 0 0 0 0 0 0 0 0 0 0 0
00010000 0 0 0 0 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0 0 0 0 0
00000000 0 0 0 0 0 0 0 0 0 0 0 0
00030001 0f070a0b 0 0 0 0 0 0 0 f 0b0b0b0b 0a0a0a0a 77777777
00030001 10000008 0 0 0 0 0 0 0 10 0 0 0
80000000 0 0 0 0 0 0 0 0 0 0 0 0

// ==== filelist.f ====
logic/pipe_pkg.sv
logic/gpr_file.sv
logic/operand_forward.sv
logic/issue_register.sv
logic/operand_issue.sv
bench/operand_issue_tb.sv

// ==== Makefile ====
# Verilator build and run for the operand stage testbench

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= operand_issue_tb
RTL_TOP   ?= operand_issue
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation passed" $(LOG)

lint:
	$(VERILATOR) --lint-only -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
